//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_rx_fifo
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the run prints the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^Result: PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

//--- common/rx_fifo_pkg.sv
// --------------------
// Shared widths, depths and types of the I2S receive sample buffer
// FIFO depths must be powers of two
// LEVEL_W must hold MONO_DEPTH itself, not only MONO_DEPTH - 1
// Mode, channel select and DMA busy are quasi-static
// --------------------

package rx_fifo_pkg;

    // --------------------
    // Widths and depths
    // --------------------

    // One audio sample
    localparam int SAMPLE_W     = 16;

    // Read word, two samples side by side
    localparam int RD_WORD_W    = 2 * SAMPLE_W;

    // Per-channel FIFOs in stereo mode
    localparam int STEREO_DEPTH = 512;

    // Single FIFO in mono mode, twice as deep
    localparam int MONO_DEPTH   = 1024;

    // Level count, 0 up to MONO_DEPTH inclusive
    localparam int LEVEL_W      = 11;

    // --------------------
    // Enums
    // --------------------

    // Channel tag carried with each sample
    typedef enum logic
    {
        CHAN_LEFT  = 1'b0,
        CHAN_RIGHT = 1'b1
    } chan_e;

    // Buffer organization
    typedef enum logic
    {
        MODE_MONO   = 1'b0,
        MODE_STEREO = 1'b1
    } rx_mode_e;

    // --------------------
    // Structs
    // --------------------

    // Sample from the I2S receiver, 17 bits
    typedef struct packed
    {
        logic [SAMPLE_W-1:0] data;
        chan_e               chan;
    } sample_t;

    // Static configuration, 3 bits
    typedef struct packed
    {
        rx_mode_e mode;
        chan_e    mono_sel;
        logic     dma_busy;
    } rx_cfg_t;

    // Per-FIFO status, 13 bits
    typedef struct packed
    {
        logic [LEVEL_W-1:0] level;
        logic               full;
        logic               empty;
    } fifo_status_t;

endpackage

//--- rtl/sample_fifo.sv
// --------------------
// Single-clock show-ahead FIFO for audio samples
// DEPTH must be a power of two, pointers wrap on overflow
// Head word is read asynchronously from the storage array
// Push while full and pop while empty are ignored
// Synchronous flush wins over push and pop on the same edge
// --------------------

`timescale 1ns/1ps

module sample_fifo
#(
    parameter int DEPTH = rx_fifo_pkg::STEREO_DEPTH
)
(
    input  logic                             WBs_CLK_i,
    input  logic                             WBs_RST_i,

    // Control strobes
    input  logic                             flush_i,
    input  logic                             push_i,
    input  logic                             pop_i,

    // Data in and head of queue out
    input  logic [rx_fifo_pkg::SAMPLE_W-1:0] wr_data_i,
    output logic [rx_fifo_pkg::SAMPLE_W-1:0] rd_data_o,

    // Level, full, empty
    output rx_fifo_pkg::fifo_status_t        status_o
);

    import rx_fifo_pkg::*;

    // Sample storage, no reset
    logic [SAMPLE_W-1:0]      mem [DEPTH];

    // Circular pointers
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;

    // Entry count, own counter per FIFO
    logic [LEVEL_W-1:0]       level;

    logic                     full;
    logic                     empty;

    // Qualified strobes
    logic                     do_push;
    logic                     do_pop;

    // --------------------
    // Flags
    // --------------------

    assign full    = (level == LEVEL_W'(DEPTH));
    assign empty   = (level == '0);

    // Drop writes into a full queue
    assign do_push = push_i & ~full;

    // Drop reads from an empty queue
    assign do_pop  = pop_i & ~empty;

    // --------------------
    // Pointers and level
    // --------------------

    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end
        else if (flush_i)
        begin
            // Discard everything, storage contents are don't care
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end

            if (do_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            // Push and pop together hold the level
            case ({do_push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // Write port
    always_ff @(posedge WBs_CLK_i)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    // --------------------
    // Outputs
    // --------------------

    // Stale contents are masked while empty
    assign rd_data_o = empty ? '0 : mem[rd_ptr];

    always_comb
    begin
        status_o.level = level;
        status_o.full  = full;
        status_o.empty = empty;
    end

endmodule

//--- rx_fifo/rx_channel_router.sv
// --------------------
// Sample steering and read-word assembly, purely combinational
// Mode, mono channel select and DMA busy must not change mid-stream
// Off-channel samples in mono mode are always accepted and dropped
// --------------------

`timescale 1ns/1ps

module rx_channel_router
(
    // Static configuration
    input  rx_fifo_pkg::rx_cfg_t              cfg_i,

    // Sample handshake from the I2S receiver
    input  rx_fifo_pkg::sample_t              sample_i,
    input  logic                              sample_valid_i,
    output logic                              sample_ready_o,

    // Pop strobes from processor and DMA
    input  logic                              cpu_pop_i,
    input  logic                              dma_pop_i,

    // FIFO status
    input  rx_fifo_pkg::fifo_status_t         left_status_i,
    input  rx_fifo_pkg::fifo_status_t         right_status_i,
    input  rx_fifo_pkg::fifo_status_t         mono_status_i,

    // FIFO head words
    input  logic [rx_fifo_pkg::SAMPLE_W-1:0]  left_data_i,
    input  logic [rx_fifo_pkg::SAMPLE_W-1:0]  right_data_i,
    input  logic [rx_fifo_pkg::SAMPLE_W-1:0]  mono_data_i,

    // FIFO strobes
    output logic                              left_push_o,
    output logic                              right_push_o,
    output logic                              mono_push_o,
    output logic                              left_pop_o,
    output logic                              right_pop_o,
    output logic                              mono_pop_o,

    // Shared write data, assembled read word
    output logic [rx_fifo_pkg::SAMPLE_W-1:0]  wr_data_o,
    output logic [rx_fifo_pkg::RD_WORD_W-1:0] rd_data_o
);

    import rx_fifo_pkg::*;

    logic stereo;
    logic is_left;
    logic mono_hit;
    logic accept;
    logic pop_sel;

    // --------------------
    // Push side
    // --------------------

    assign stereo   = (cfg_i.mode == MODE_STEREO);
    assign is_left  = (sample_i.chan == CHAN_LEFT);

    // Sample belongs to the channel kept in mono mode
    assign mono_hit = (sample_i.chan == cfg_i.mono_sel);

    // Back-pressure only from the FIFO the sample is headed for
    always_comb
    begin
        if (stereo)
        begin
            sample_ready_o = is_left ? ~left_status_i.full : ~right_status_i.full;
        end
        else
        begin
            sample_ready_o = mono_hit ? ~mono_status_i.full : 1'b1;
        end
    end

    assign accept       = sample_valid_i & sample_ready_o;

    // Accepted off-channel mono samples push nowhere
    assign left_push_o  = accept & stereo & is_left;
    assign right_push_o = accept & stereo & ~is_left;
    assign mono_push_o  = accept & ~stereo & mono_hit;

    assign wr_data_o    = sample_i.data;

    // --------------------
    // Pop side
    // --------------------

    // DMA owns the read port while busy
    assign pop_sel     = cfg_i.dma_busy ? dma_pop_i : cpu_pop_i;

    // Stereo pop takes one word off each channel FIFO
    assign left_pop_o  = pop_sel & stereo & ~left_status_i.empty;
    assign right_pop_o = pop_sel & stereo & ~right_status_i.empty;
    assign mono_pop_o  = pop_sel & ~stereo & ~mono_status_i.empty;

    // Right sample in the upper half, mono sample duplicated
    assign rd_data_o   = stereo ? {right_data_i, left_data_i} : {mono_data_i, mono_data_i};

endmodule

//--- rx_fifo/rx_fifo_top.sv
// --------------------
// I2S receive sample buffer on the fabric clock
// Left and right FIFOs in stereo mode, one deeper FIFO in mono mode
// Software flushes after any mode or channel change
// Read data is combinational from the FIFO heads
// --------------------

`timescale 1ns/1ps

module rx_fifo_top
(
    input  logic                              WBs_CLK_i,
    input  logic                              WBs_RST_i,

    // Control
    input  logic                              flush_i,
    input  rx_fifo_pkg::rx_cfg_t              cfg_i,

    // Sample handshake
    input  rx_fifo_pkg::sample_t              sample_i,
    input  logic                              sample_valid_i,
    output logic                              sample_ready_o,

    // Read side
    input  logic                              cpu_pop_i,
    input  logic                              dma_pop_i,
    output logic [rx_fifo_pkg::RD_WORD_W-1:0] rd_data_o,

    // Status per FIFO
    output rx_fifo_pkg::fifo_status_t         left_status_o,
    output rx_fifo_pkg::fifo_status_t         right_status_o,
    output rx_fifo_pkg::fifo_status_t         mono_status_o
);

    import rx_fifo_pkg::*;

    // Router to FIFO strobes
    logic                left_push;
    logic                right_push;
    logic                mono_push;
    logic                left_pop;
    logic                right_pop;
    logic                mono_pop;

    // Shared write data
    logic [SAMPLE_W-1:0] wr_data;

    // Head words back to the router
    logic [SAMPLE_W-1:0] left_data;
    logic [SAMPLE_W-1:0] right_data;
    logic [SAMPLE_W-1:0] mono_data;

    // --------------------
    // Steering
    // --------------------

    rx_channel_router u_router
    (
        .cfg_i          (cfg_i),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .sample_ready_o (sample_ready_o),
        .cpu_pop_i      (cpu_pop_i),
        .dma_pop_i      (dma_pop_i),
        .left_status_i  (left_status_o),
        .right_status_i (right_status_o),
        .mono_status_i  (mono_status_o),
        .left_data_i    (left_data),
        .right_data_i   (right_data),
        .mono_data_i    (mono_data),
        .left_push_o    (left_push),
        .right_push_o   (right_push),
        .mono_push_o    (mono_push),
        .left_pop_o     (left_pop),
        .right_pop_o    (right_pop),
        .mono_pop_o     (mono_pop),
        .wr_data_o      (wr_data),
        .rd_data_o      (rd_data_o)
    );

    // --------------------
    // Storage
    // --------------------

    // Left channel, stereo only
    sample_fifo #(.DEPTH(STEREO_DEPTH)) u_left_fifo
    (
        .WBs_CLK_i (WBs_CLK_i),
        .WBs_RST_i (WBs_RST_i),
        .flush_i   (flush_i),
        .push_i    (left_push),
        .pop_i     (left_pop),
        .wr_data_i (wr_data),
        .rd_data_o (left_data),
        .status_o  (left_status_o)
    );

    // Right channel, stereo only
    sample_fifo #(.DEPTH(STEREO_DEPTH)) u_right_fifo
    (
        .WBs_CLK_i (WBs_CLK_i),
        .WBs_RST_i (WBs_RST_i),
        .flush_i   (flush_i),
        .push_i    (right_push),
        .pop_i     (right_pop),
        .wr_data_i (wr_data),
        .rd_data_o (right_data),
        .status_o  (right_status_o)
    );

    // Selected channel, mono only
    sample_fifo #(.DEPTH(MONO_DEPTH)) u_mono_fifo
    (
        .WBs_CLK_i (WBs_CLK_i),
        .WBs_RST_i (WBs_RST_i),
        .flush_i   (flush_i),
        .push_i    (mono_push),
        .pop_i     (mono_pop),
        .wr_data_i (wr_data),
        .rd_data_o (mono_data),
        .status_o  (mono_status_o)
    );

endmodule

//--- sources.f
common/rx_fifo_pkg.sv
rtl/sample_fifo.sv
rx_fifo/rx_channel_router.sv
rx_fifo/rx_fifo_top.sv
testbench/rx_fifo_properties.sv
testbench/rx_fifo_checker.sv
testbench/tb_rx_fifo.sv

//--- testbench/rx_fifo_checker.sv
// --------------------
// Reference model of the left, right and mono queues
// Updates on the rising edge, compares on the falling edge
// Pops and pushes are judged against the model, not the DUT flags
// --------------------

`timescale 1ns/1ps

module rx_fifo_checker
(
    input  logic                              WBs_CLK_i,
    input  logic                              WBs_RST_i,
    input  logic                              flush_i,
    input  rx_fifo_pkg::rx_cfg_t              cfg_i,
    input  rx_fifo_pkg::sample_t              sample_i,
    input  logic                              sample_valid_i,
    input  logic                              sample_ready_i,
    input  logic                              cpu_pop_i,
    input  logic                              dma_pop_i,
    input  logic [rx_fifo_pkg::RD_WORD_W-1:0] rd_data_i,
    input  rx_fifo_pkg::fifo_status_t         left_status_i,
    input  rx_fifo_pkg::fifo_status_t         right_status_i,
    input  rx_fifo_pkg::fifo_status_t         mono_status_i
);

    import rx_fifo_pkg::*;

    logic [SAMPLE_W-1:0] left_q[$];
    logic [SAMPLE_W-1:0] right_q[$];
    logic [SAMPLE_W-1:0] mono_q[$];

    int    model_errs  = 0;
    int    golden_errs = 0;
    string test_name   = "reset";

    // --------------------
    // Expected values
    // --------------------

    function automatic logic expected_ready();
        if (cfg_i.mode == MODE_STEREO)
        begin
            if (sample_i.chan == CHAN_LEFT)
            begin
                return left_q.size() < STEREO_DEPTH;
            end
            return right_q.size() < STEREO_DEPTH;
        end
        // Other channel is swallowed
        if (sample_i.chan != cfg_i.mono_sel)
        begin
            return 1'b1;
        end
        return mono_q.size() < MONO_DEPTH;
    endfunction

    // Empty queues read as zero
    function automatic logic [RD_WORD_W-1:0] expected_word();
        logic [SAMPLE_W-1:0] l;
        logic [SAMPLE_W-1:0] r;
        logic [SAMPLE_W-1:0] m;
        l = (left_q.size() > 0) ? left_q[0] : '0;
        r = (right_q.size() > 0) ? right_q[0] : '0;
        m = (mono_q.size() > 0) ? mono_q[0] : '0;
        return (cfg_i.mode == MODE_STEREO) ? {r, l} : {m, m};
    endfunction

    function automatic fifo_status_t status_of(input int size, input int depth);
        fifo_status_t s;
        s.level = LEVEL_W'(size);
        s.full  = (size == depth);
        s.empty = (size == 0);
        return s;
    endfunction

    // One ERR line per differing value
    function automatic int mismatch(input string what, input logic [31:0] exp,
                                    input logic [31:0] act);
        if (exp !== act)
        begin
            $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
            return 1;
        end
        return 0;
    endfunction

    // --------------------
    // Model update
    // --------------------

    always @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        logic rdy;
        logic pop_sel;
        if (WBs_RST_i || flush_i)
        begin
            left_q.delete();
            right_q.delete();
            mono_q.delete();
        end
        else
        begin
            // Ready and pop targets from the state before the edge
            rdy     = expected_ready();
            pop_sel = cfg_i.dma_busy ? dma_pop_i : cpu_pop_i;
            if (pop_sel && cfg_i.mode == MODE_STEREO)
            begin
                if (left_q.size() > 0)
                begin
                    void'(left_q.pop_front());
                end
                if (right_q.size() > 0)
                begin
                    void'(right_q.pop_front());
                end
            end
            else if (pop_sel && mono_q.size() > 0)
            begin
                void'(mono_q.pop_front());
            end
            if (sample_valid_i && rdy)
            begin
                if (cfg_i.mode == MODE_STEREO && sample_i.chan == CHAN_LEFT)
                begin
                    left_q.push_back(sample_i.data);
                end
                else if (cfg_i.mode == MODE_STEREO)
                begin
                    right_q.push_back(sample_i.data);
                end
                else if (sample_i.chan == cfg_i.mono_sel)
                begin
                    mono_q.push_back(sample_i.data);
                end
            end
        end
    end

    // --------------------
    // Continuous comparison
    // --------------------

    always @(negedge WBs_CLK_i)
    begin
        if (!WBs_RST_i)
        begin
            model_errs += mismatch("ready", 32'(expected_ready()), 32'(sample_ready_i));
            model_errs += mismatch("rd_data", expected_word(), rd_data_i);
            model_errs += mismatch("left_status", 32'(status_of(left_q.size(), STEREO_DEPTH)),
                                   32'(left_status_i));
            model_errs += mismatch("right_status",
                                   32'(status_of(right_q.size(), STEREO_DEPTH)),
                                   32'(right_status_i));
            model_errs += mismatch("mono_status", 32'(status_of(mono_q.size(), MONO_DEPTH)),
                                   32'(mono_status_i));
        end
    end

    // Golden-file values, called by the testbench on a falling edge
    task automatic check_expect(input string name, input bit check_word,
                                input logic [31:0] word, input logic [31:0] ll,
                                input logic [31:0] lr, input logic [31:0] lm,
                                input logic [31:0] rdy);
        test_name = name;
        if (check_word)
        begin
            golden_errs += mismatch("rd_data", word, rd_data_i);
        end
        golden_errs += mismatch("left_level", ll, 32'(left_status_i.level));
        golden_errs += mismatch("right_level", lr, 32'(right_status_i.level));
        golden_errs += mismatch("mono_level", lm, 32'(mono_status_i.level));
        golden_errs += mismatch("ready", rdy, 32'(sample_ready_i));
    endtask

endmodule

//--- testbench/rx_fifo_golden.txt
# Values in hex. MODE mode(1 stereo) mono_sel(1 right) dma_busy | PUSH chan data | POP src(1 dma)
# FLUSH with_push | FILL chan count | EXPECT name word(- skips) left right mono ready
EXPECT reset 00000000 0 0 0 1
PUSH 0 1111
PUSH 1 2222
PUSH 0 3333
PUSH 1 4444
EXPECT stereo_fill 22221111 2 2 0 1
POP 0
EXPECT stereo_pop1 44443333 1 1 0 1
POP 0
EXPECT stereo_pop2 00000000 0 0 0 1
FLUSH 0
MODE 0 1 0
PUSH 1 aaaa
PUSH 0 bbbb
PUSH 1 cccc
EXPECT mono_fill aaaaaaaa 0 0 2 1
POP 0
EXPECT mono_pop cccccccc 0 0 1 1
MODE 0 1 1
POP 0
EXPECT dma_cpu_ignored cccccccc 0 0 1 1
POP 1
EXPECT dma_pop 00000000 0 0 0 1
PUSH 1 dddd
MODE 0 1 0
POP 1
EXPECT cpu_dma_ignored dddddddd 0 0 1 1
POP 0
EXPECT cpu_pop 00000000 0 0 0 1
FLUSH 0
MODE 1 0 0
FILL 0 200
EXPECT bp_full - 200 0 0 0
PUSH 1 5555
EXPECT bp_right - 200 1 0 1
POP 0
PUSH 0 6666
EXPECT bp_refill - 200 0 0 0
PUSH 1 7777
FLUSH 1
EXPECT flush 00000000 0 0 0 1

//--- testbench/rx_fifo_properties.sv
// --------------------
// FIFO flag and flush properties, bound to every sample_fifo
// Checks are off while reset is high
// --------------------

`timescale 1ns/1ps

module rx_fifo_properties
#(
    parameter int DEPTH = rx_fifo_pkg::STEREO_DEPTH
)
(
    input  logic                      WBs_CLK_i,
    input  logic                      WBs_RST_i,
    input  logic                      flush_i,
    input  rx_fifo_pkg::fifo_status_t status_i
);

    import rx_fifo_pkg::*;

    // Failed properties of this FIFO
    int fail_count = 0;

    // Flags are mutually exclusive
    a_flags_exclusive: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        !(status_i.full && status_i.empty))
    else
    begin
        fail_count++;
        $error("FIFO full and empty are high together");
    end

    // Never more entries than storage
    a_level_bound: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        status_i.level <= LEVEL_W'(DEPTH))
    else
    begin
        fail_count++;
        $error("FIFO level exceeds its depth");
    end

    // Flush clears the queue in one edge
    a_flush_empties: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        flush_i |=> status_i.empty)
    else
    begin
        fail_count++;
        $error("FIFO not empty one cycle after flush");
    end

endmodule

bind sample_fifo rx_fifo_properties #(.DEPTH(DEPTH)) u_props
(
    .WBs_CLK_i (WBs_CLK_i),
    .WBs_RST_i (WBs_RST_i),
    .flush_i   (flush_i),
    .status_i  (status_o)
);

//--- testbench/tb_rx_fifo.sv
// --------------------
// Testbench for rx_fifo_top, driven by a golden command file
// Commands run one after another, each starting on a rising edge
// Random FILL data from a 32-bit xorshift, seed 16
// --------------------

`timescale 1ns/1ps

module tb_rx_fifo;

    import rx_fifo_pkg::*;

    localparam string GOLDEN_FILE = "testbench/rx_fifo_golden.txt";

    logic                 WBs_CLK_i;
    logic                 WBs_RST_i;
    logic                 flush;
    rx_cfg_t              cfg;
    sample_t              sample;
    logic                 sample_valid;
    logic                 sample_ready;
    logic                 cpu_pop;
    logic                 dma_pop;
    logic [RD_WORD_W-1:0] rd_data;
    fifo_status_t         left_status;
    fifo_status_t         right_status;
    fifo_status_t         mono_status;

    string       lines[$];
    int          cycles      = 0;
    int          cycle_limit = 0;
    int          file_errs   = 0;
    logic [31:0] rng_state   = 32'd16;

    rx_fifo_top dut
    (
        .WBs_CLK_i      (WBs_CLK_i),
        .WBs_RST_i      (WBs_RST_i),
        .flush_i        (flush),
        .cfg_i          (cfg),
        .sample_i       (sample),
        .sample_valid_i (sample_valid),
        .sample_ready_o (sample_ready),
        .cpu_pop_i      (cpu_pop),
        .dma_pop_i      (dma_pop),
        .rd_data_o      (rd_data),
        .left_status_o  (left_status),
        .right_status_o (right_status),
        .mono_status_o  (mono_status)
    );

    rx_fifo_checker chk
    (
        .WBs_CLK_i      (WBs_CLK_i),
        .WBs_RST_i      (WBs_RST_i),
        .flush_i        (flush),
        .cfg_i          (cfg),
        .sample_i       (sample),
        .sample_valid_i (sample_valid),
        .sample_ready_i (sample_ready),
        .cpu_pop_i      (cpu_pop),
        .dma_pop_i      (dma_pop),
        .rd_data_i      (rd_data),
        .left_status_i  (left_status),
        .right_status_i (right_status),
        .mono_status_i  (mono_status)
    );

    // 100 ns period
    always #50 WBs_CLK_i = ~WBs_CLK_i;

    // --------------------
    // Watchdog
    // --------------------

    always @(posedge WBs_CLK_i)
    begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit)
        begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Strobes last one edge, sample data is held
    task automatic drop_strobes();
        sample_valid <= 1'b0;
        cpu_pop      <= 1'b0;
        dma_pop      <= 1'b0;
        flush        <= 1'b0;
    endtask

    // Offer a sample, return once the next rising edge takes it
    task automatic push_sample(input logic c, input logic [SAMPLE_W-1:0] d);
        @(posedge WBs_CLK_i);
        drop_strobes();
        sample.data  <= d;
        sample.chan  <= chan_e'(c);
        sample_valid <= 1'b1;
        @(negedge WBs_CLK_i);
        while (!sample_ready)
        begin
            @(negedge WBs_CLK_i);
        end
    endtask

    task automatic run_command(input string line);
        string       cmd;
        string       name;
        string       wstr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] word;
        if (line.len() == 0 || line[0] == "#" || $sscanf(line, "%s", cmd) < 1)
        begin
            return;
        end
        if (cmd == "MODE")
        begin
            void'($sscanf(line, "%s %h %h %h", cmd, a, b, c));
            @(posedge WBs_CLK_i);
            drop_strobes();
            cfg <= '{mode: rx_mode_e'(a[0]), mono_sel: chan_e'(b[0]), dma_busy: c[0]};
        end
        else if (cmd == "PUSH")
        begin
            void'($sscanf(line, "%s %h %h", cmd, a, b));
            push_sample(a[0], b[SAMPLE_W-1:0]);
        end
        else if (cmd == "FILL")
        begin
            void'($sscanf(line, "%s %h %h", cmd, a, b));
            for (int i = 0; i < int'(b); i++)
            begin
                rng_state = next_random(rng_state);
                push_sample(a[0], rng_state[SAMPLE_W-1:0]);
            end
        end
        else if (cmd == "POP")
        begin
            void'($sscanf(line, "%s %h", cmd, a));
            @(posedge WBs_CLK_i);
            drop_strobes();
            if (a[0])
            begin
                dma_pop <= 1'b1;
            end
            else
            begin
                cpu_pop <= 1'b1;
            end
        end
        else if (cmd == "FLUSH")
        begin
            // Optional push on the same edge
            void'($sscanf(line, "%s %h", cmd, a));
            @(posedge WBs_CLK_i);
            drop_strobes();
            flush        <= 1'b1;
            sample_valid <= a[0];
        end
        else if (cmd == "EXPECT")
        begin
            void'($sscanf(line, "%s %s %s %h %h %h %h", cmd, name, wstr, a, b, c, d));
            @(posedge WBs_CLK_i);
            drop_strobes();
            @(negedge WBs_CLK_i);
            word = '0;
            if (wstr != "-")
            begin
                void'($sscanf(wstr, "%h", word));
            end
            chk.check_expect(name, wstr != "-", word, a, b, c, d);
        end
        else
        begin
            $display("Unknown command in golden file: %s", cmd);
            file_errs++;
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial
    begin
        string       line;
        string       cmd;
        int          fd;
        int          fill_total;
        int          assert_errs;
        logic [31:0] a;
        logic [31:0] b;
        WBs_CLK_i    = 1'b0;
        WBs_RST_i    = 1'b1;
        flush        = 1'b0;
        cfg          = '{mode: MODE_STEREO, mono_sel: CHAN_LEFT, dma_busy: 1'b0};
        sample       = '{data: '0, chan: CHAN_LEFT};
        sample_valid = 1'b0;
        cpu_pop      = 1'b0;
        dma_pop      = 1'b0;
        fill_total   = 0;

        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0)
        begin
            $display("Could not open the golden file %s", GOLDEN_FILE);
            file_errs++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                if ($fgets(line, fd) > 0)
                begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end

        // Budget from command count and fill lengths
        foreach (lines[i])
        begin
            if ($sscanf(lines[i], "%s %h %h", cmd, a, b) == 3 && cmd == "FILL")
            begin
                fill_total += int'(b);
            end
        end
        cycle_limit = 10 + 4 * lines.size() + 2 * fill_total + 50;

        repeat (10) @(posedge WBs_CLK_i);
        WBs_RST_i <= 1'b0;

        foreach (lines[i])
        begin
            run_command(lines[i]);
        end
        @(posedge WBs_CLK_i);
        drop_strobes();
        @(negedge WBs_CLK_i);

        // Property failures of the three bound FIFO checkers
        assert_errs = dut.u_left_fifo.u_props.fail_count
                    + dut.u_right_fifo.u_props.fail_count
                    + dut.u_mono_fifo.u_props.fail_count;

        $display("Errors: model %0d, golden %0d, file %0d, assertion %0d",
                 chk.model_errs, chk.golden_errs, file_errs, assert_errs);
        if (chk.model_errs + chk.golden_errs + file_errs + assert_errs == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
